/* sources.f */
logic/ctr_pkg.sv
logic/ram_port_if.sv
logic/ram_dualport.sv
logic/ram_dualport_init.sv
logic/counter_update_pipe.sv
logic/host_read_port.sv
logic/event_counter_top.sv
tests/event_counter_sva.sv
tests/event_counter_tb.sv

/* Bender.yml */
package:
  name: event_counter

sources:
  - logic/ctr_pkg.sv
  - logic/ram_port_if.sv
  - logic/ram_dualport.sv
  - logic/ram_dualport_init.sv
  - logic/counter_update_pipe.sv
  - logic/host_read_port.sv
  - logic/event_counter_top.sv
  - target: test
    files:
      - tests/event_counter_sva.sv
      - tests/event_counter_tb.sv

/* tests/event_counter_tb.sv */
// ------------------------------------------------
// Fixed seed; stops at the first mismatch, timeout or failed assertion
// ------------------------------------------------
`timescale 1ns/1ps

module event_counter_tb;
    import ctr_pkg::*;

    // Wait limits in clock cycles
    localparam int ACK_TIMEOUT   = 100;
    localparam int READY_TIMEOUT = 200;

    logic   clk1;
    logic   reset;
    logic   event_valid;
    idx_t   event_index;
    incr_t  event_incr;
    logic   event_ready;
    logic   rd_req;
    idx_t   rd_index;
    logic   rd_ack;
    count_t rd_count;

    // Expected value of every counter
    count_t model [N_ENTRIES];
    int unsigned seed_init;

    event_counter_top u_event_counter_top
    (
        .clk1(clk1),
        .reset(reset),
        .event_valid(event_valid),
        .event_index(event_index),
        .event_incr(event_incr),
        .event_ready(event_ready),
        .rd_req(rd_req),
        .rd_index(rd_index),
        .rd_ack(rd_ack),
        .rd_count(rd_count)
    );

    // 8 ns period
    always #4 clk1 = ~clk1;

    // Watch the bound checker for failed assertions
    always @(negedge clk1)
    begin
        if (u_event_counter_top.u_sva.fail_count != 0)
        begin
            $display("Verification failed");
            $fatal(1, "Stopped on a failed assertion");
        end
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected)
        begin
            $display("** Error: %s = 0x%0h, expected 0x%0h", name, actual, expected);
            $display("Verification failed");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    task automatic fail_timeout(input string what);
        $display("Timed out while waiting for %s", what);
        $display("Verification failed");
        $fatal(1, "Stopped on a timeout");
    endtask

    // Counters stick at all ones once they reach the top
    function automatic count_t sat_add(input count_t value, input incr_t incr);
        logic [COUNT_W:0] total;
        total = {1'b0, value} + incr;
        return (total > 17'h0ffff) ? 16'hffff : total[COUNT_W-1:0];
    endfunction

    // Reset for two cycles, then count the cycles until the clear finishes
    task automatic apply_reset();
        int cycles;
        @(posedge clk1);
        reset       <= 1'b1;
        event_valid <= 1'b0;
        rd_req      <= 1'b0;
        repeat (2) @(posedge clk1);
        reset <= 1'b0;
        for (int i = 0; i < N_ENTRIES; i++)
        begin
            model[i] = '0;
        end
        cycles = 0;
        @(negedge clk1);
        check_value("rd_ack", rd_ack, 0);
        while (!event_ready)
        begin
            cycles++;
            if (cycles > READY_TIMEOUT)
            begin
                fail_timeout("event_ready after reset");
            end
            @(negedge clk1);
        end
        check_value("ready_latency", cycles, N_ENTRIES);
    endtask

    // Ready is known high here, so each driven event is accepted
    task automatic drive_event(input idx_t idx, input incr_t incr);
        @(posedge clk1);
        event_valid <= 1'b1;
        event_index <= idx;
        event_incr  <= incr;
        model[idx] = sat_add(model[idx], incr);
    endtask

    task automatic stop_events();
        @(posedge clk1);
        event_valid <= 1'b0;
    endtask

    task automatic wait_ack(input logic level, input string what);
        int cycles;
        cycles = 0;
        @(negedge clk1);
        while (rd_ack !== level)
        begin
            cycles++;
            if (cycles > ACK_TIMEOUT)
            begin
                fail_timeout(what);
            end
            @(negedge clk1);
        end
    endtask

    // Full four-phase read of one counter, compared with the model
    task automatic host_read(input idx_t idx);
        @(posedge clk1);
        rd_req   <= 1'b1;
        rd_index <= idx;
        wait_ack(1'b1, "rd_ack to rise");
        check_value("rd_count", rd_count, model[idx]);
        @(posedge clk1);
        rd_req <= 1'b0;
        wait_ack(1'b0, "rd_ack to fall");
    endtask

    task automatic read_all();
        for (int i = 0; i < N_ENTRIES; i++)
        begin
            host_read(idx_t'(i));
        end
    endtask

    // Request a read, then keep the slot busy with a stream of events
    task automatic read_during_stream(input idx_t idx, input int n_events);
        idx_t ev_idx;
        @(posedge clk1);
        rd_req   <= 1'b1;
        rd_index <= idx;
        for (int i = 0; i < n_events; i++)
        begin
            ev_idx = ($urandom % 2) ? idx : idx_t'($urandom);
            drive_event(ev_idx, incr_t'($urandom));
            @(negedge clk1);
            check_value("rd_ack", rd_ack, 0);
        end
        stop_events();
        wait_ack(1'b1, "rd_ack after the event stream");
        check_value("rd_count", rd_count, model[idx]);
        @(posedge clk1);
        rd_req <= 1'b0;
        wait_ack(1'b0, "rd_ack to fall");
    endtask

    initial
    begin
        idx_t prev_idx;
        idx_t sat_idx;
        seed_init   = $urandom(32'hf5ba);
        clk1        = 1'b0;
        reset       = 1'b1;
        event_valid = 1'b0;
        event_index = '0;
        event_incr  = '0;
        rd_req      = 1'b0;
        rd_index    = '0;

        // Cleared table reads zero at random places
        apply_reset();
        repeat (8) host_read(idx_t'($urandom));

        // Burst with many back-to-back hits on one index
        prev_idx = idx_t'($urandom);
        for (int i = 0; i < 300; i++)
        begin
            if ($urandom % 2)
            begin
                prev_idx = idx_t'($urandom);
            end
            drive_event(prev_idx, incr_t'($urandom));
        end
        stop_events();
        read_all();

        // Enough increments of 15 to pass the top of the range
        sat_idx = idx_t'($urandom);
        for (int i = 0; i < 4400; i++)
        begin
            drive_event(sat_idx, 4'hf);
        end
        stop_events();
        host_read(sat_idx);
        check_value("rd_count_saturated", rd_count, 16'hffff);
        host_read(sat_idx - 1'b1);
        host_read(sat_idx + 1'b1);

        // Reads held off by a running event stream
        for (int r = 0; r < 6; r++)
        begin
            read_during_stream(idx_t'($urandom), 5 + ($urandom % 10));
        end
        read_all();

        // Reset in the middle of a burst wipes the whole table
        for (int i = 0; i < 50; i++)
        begin
            drive_event(idx_t'($urandom), incr_t'($urandom));
        end
        apply_reset();
        read_all();

        if (u_event_counter_top.u_sva.fail_count == 0)
        begin
            $display("Verification passed");
            $finish;
        end
        else
        begin
            $display("Verification failed");
            $fatal(1, "Assertions reported errors");
        end
    end

endmodule

/* tests/event_counter_sva.sv */
// ------------------------------------------------
// Sampled on clk1; only the reset check runs during reset
// ------------------------------------------------
`timescale 1ns/1ps

module event_counter_sva
(
    input logic clk1,
    input logic reset,
    input logic event_ready,
    input logic rd_req,
    input logic rd_ack
);

    // Number of failed assertions so far
    int fail_count = 0;

    // The handshake always starts from a low ack
    assert property (@(posedge clk1) reset |=> !rd_ack)
    else
    begin
        $error("rd_ack high in the cycle after reset");
        fail_count++;
    end

    // An ack only answers a pending request
    assert property (@(posedge clk1) disable iff (reset) $rose(rd_ack) |-> rd_req)
    else
    begin
        $error("rd_ack rose without rd_req");
        fail_count++;
    end

    // Ack is held until the host lets go of its request
    assert property (@(posedge clk1) disable iff (reset) rd_ack && rd_req |=> rd_ack)
    else
    begin
        $error("rd_ack fell while rd_req was still high");
        fail_count++;
    end

    // Once the RAM is cleared it stays usable until the next reset
    assert property (@(posedge clk1) disable iff (reset) event_ready |=> event_ready)
    else
    begin
        $error("event_ready fell without reset");
        fail_count++;
    end

endmodule

bind event_counter_top event_counter_sva u_sva
(
    .clk1(clk1),
    .reset(reset),
    .event_ready(event_ready),
    .rd_req(rd_req),
    .rd_ack(rd_ack)
);

/* logic/event_counter_top.sv */
// ------------------------------------------------
// Events are refused for N_ENTRIES cycles after reset
// ------------------------------------------------
`timescale 1ns/1ps

module event_counter_top
#(
    parameter int N_OUTPUT_REG_STAGES = 1
)
(
    input  logic            clk1,
    input  logic            reset,
    input  logic            event_valid,
    input  ctr_pkg::idx_t   event_index,
    input  ctr_pkg::incr_t  event_incr,
    output logic            event_ready,
    input  logic            rd_req,
    input  ctr_pkg::idx_t   rd_index,
    output logic            rd_ack,
    output ctr_pkg::count_t rd_count
);
    import ctr_pkg::*;

    logic   slot_req;
    idx_t   slot_index;
    logic   slot_grant;
    logic   slot_valid;
    count_t slot_count;

    // Port 0 carries reads, port 1 carries writes
    ram_port_if #(.N_ENTRIES(N_ENTRIES), .N_DATA_BITS(COUNT_W)) port0_if ();
    ram_port_if #(.N_ENTRIES(N_ENTRIES), .N_DATA_BITS(COUNT_W)) port1_if ();

    // The RAM ready flag is the event ready
    ram_dualport_init
    #(
        .N_ENTRIES(N_ENTRIES),
        .N_DATA_BITS(COUNT_W),
        .N_OUTPUT_REG_STAGES(N_OUTPUT_REG_STAGES)
    )
    u_ram
    (
        .clk1(clk1),
        .reset(reset),
        .rdy(event_ready),
        .port0(port0_if.mem),
        .port1(port1_if.mem)
    );

    counter_update_pipe #(.N_OUTPUT_REG_STAGES(N_OUTPUT_REG_STAGES)) u_pipe
    (
        .clk1(clk1),
        .reset(reset),
        .rdy(event_ready),
        .event_valid(event_valid),
        .event_index(event_index),
        .event_incr(event_incr),
        .slot_req(slot_req),
        .slot_index(slot_index),
        .slot_grant(slot_grant),
        .slot_valid(slot_valid),
        .slot_count(slot_count),
        .port0(port0_if.user),
        .port1(port1_if.user)
    );

    host_read_port u_host_read
    (
        .clk1(clk1),
        .reset(reset),
        .rd_req(rd_req),
        .rd_index(rd_index),
        .rd_ack(rd_ack),
        .rd_count(rd_count),
        .slot_req(slot_req),
        .slot_index(slot_index),
        .slot_grant(slot_grant),
        .slot_valid(slot_valid),
        .slot_count(slot_count)
    );

endmodule

/* logic/host_read_port.sv */
// ------------------------------------------------
// rd_index must stay stable while rd_req is high
// ------------------------------------------------
`timescale 1ns/1ps

module host_read_port
(
    input  logic            clk1,
    input  logic            reset,
    input  logic            rd_req,
    input  ctr_pkg::idx_t   rd_index,
    output logic            rd_ack,
    output ctr_pkg::count_t rd_count,
    output logic            slot_req,
    output ctr_pkg::idx_t   slot_index,
    input  logic            slot_grant,
    input  logic            slot_valid,
    input  ctr_pkg::count_t slot_count
);

    typedef enum logic [1:0] {IDLE, WAIT_SLOT, WAIT_DATA, ACK} upd_state_t;

    upd_state_t state;

    // Ask for the read slot until the pipeline grants it
    assign slot_req   = (state == WAIT_SLOT);
    assign slot_index = rd_index;
    assign rd_ack     = (state == ACK);

    always_ff @(posedge clk1)
    begin
        if (reset)
        begin
            state <= IDLE;
        end
        else
        begin
            case (state)
                IDLE:      if (rd_req) state <= WAIT_SLOT;
                WAIT_SLOT: if (slot_grant) state <= WAIT_DATA;
                WAIT_DATA: if (slot_valid) state <= ACK;
                // Hold the ack until the host drops its request
                ACK:       if (!rd_req) state <= IDLE;
                default:   state <= IDLE;
            endcase
        end
    end

    // Count is captured once and held through the ack phase
    always_ff @(posedge clk1)
    begin
        if (state == WAIT_DATA && slot_valid)
        begin
            rd_count <= slot_count;
        end
    end

endmodule

/* logic/counter_update_pipe.sv */
// ------------------------------------------------
// Events win the read slot; one port 0 read per cycle at most
// ------------------------------------------------
`timescale 1ns/1ps

module counter_update_pipe
#(
    parameter int N_OUTPUT_REG_STAGES = 1
)
(
    input  logic            clk1,
    input  logic            reset,
    input  logic            rdy,
    input  logic            event_valid,
    input  ctr_pkg::idx_t   event_index,
    input  ctr_pkg::incr_t  event_incr,
    input  logic            slot_req,
    input  ctr_pkg::idx_t   slot_index,
    output logic            slot_grant,
    output logic            slot_valid,
    output ctr_pkg::count_t slot_count,
    ram_port_if.user        port0,
    ram_port_if.user        port1
);
    import ctr_pkg::*;

    // Cycles from a port 0 address to its read data
    localparam int READ_LAT = 1 + N_OUTPUT_REG_STAGES;

    logic   accept;
    // Read stages, the last one lines up with port0.rdata
    logic   stage_valid [READ_LAT];
    logic   stage_event [READ_LAT];
    idx_t   stage_idx   [READ_LAT];
    incr_t  stage_incr  [READ_LAT];
    // Write stage, the final pipeline stage
    logic   wr_valid;
    logic   wr_event;
    idx_t   wr_idx;
    count_t wr_count;
    // Writes of the last READ_LAT cycles, which the RAM read may have missed
    logic   hist_valid [READ_LAT];
    idx_t   hist_idx   [READ_LAT];
    count_t hist_count [READ_LAT];
    count_t base;
    logic [COUNT_W:0] sum;
    count_t result;

    assign accept     = rdy & event_valid;
    assign slot_grant = rdy & ~event_valid & slot_req;

    // Port 0 only ever reads
    assign port0.addr  = accept ? event_index : slot_index;
    assign port0.wen   = 1'b0;
    assign port0.wdata = '0;

    // Oldest match first so that the newest value overrides it
    always_comb
    begin
        base = port0.rdata;
        for (int k = READ_LAT - 1; k >= 0; k--)
        begin
            if (hist_valid[k] && hist_idx[k] == stage_idx[READ_LAT-1])
            begin
                base = hist_count[k];
            end
        end
        if (wr_valid && wr_event && wr_idx == stage_idx[READ_LAT-1])
        begin
            base = wr_count;
        end
    end

    // Saturating add, slot reads carry a zero increment
    assign sum    = {1'b0, base} + stage_incr[READ_LAT-1];
    assign result = sum[COUNT_W] ? '1 : sum[COUNT_W-1:0];

    always_ff @(posedge clk1)
    begin
        if (reset)
        begin
            for (int s = 0; s < READ_LAT; s++)
            begin
                stage_valid[s] <= 1'b0;
                hist_valid[s]  <= 1'b0;
            end
            wr_valid <= 1'b0;
        end
        else
        begin
            stage_valid[0] <= accept | slot_grant;
            for (int s = 1; s < READ_LAT; s++)
            begin
                stage_valid[s] <= stage_valid[s-1];
            end
            wr_valid <= stage_valid[READ_LAT-1];
            // Only event results land in the RAM
            hist_valid[0] <= wr_valid & wr_event;
            for (int s = 1; s < READ_LAT; s++)
            begin
                hist_valid[s] <= hist_valid[s-1];
            end
        end
    end

    always_ff @(posedge clk1)
    begin
        stage_event[0] <= accept;
        stage_idx[0]   <= port0.addr;
        stage_incr[0]  <= accept ? event_incr : '0;
        for (int s = 1; s < READ_LAT; s++)
        begin
            stage_event[s] <= stage_event[s-1];
            stage_idx[s]   <= stage_idx[s-1];
            stage_incr[s]  <= stage_incr[s-1];
        end
        wr_event      <= stage_event[READ_LAT-1];
        wr_idx        <= stage_idx[READ_LAT-1];
        wr_count      <= result;
        hist_idx[0]   <= wr_idx;
        hist_count[0] <= wr_count;
        for (int s = 1; s < READ_LAT; s++)
        begin
            hist_idx[s]   <= hist_idx[s-1];
            hist_count[s] <= hist_count[s-1];
        end
    end

    assign port1.addr  = wr_idx;
    assign port1.wen   = wr_valid & wr_event;
    assign port1.wdata = wr_count;
    assign slot_valid  = wr_valid & ~wr_event;
    assign slot_count  = wr_count;

endmodule

/* logic/ram_dualport_init.sv */
// ------------------------------------------------
// Port 1 is ignored until rdy; clearing takes N_ENTRIES cycles
// ------------------------------------------------
`timescale 1ns/1ps

module ram_dualport_init
#(
    parameter int N_ENTRIES = 32,
    parameter int N_DATA_BITS = 64,
    parameter int N_OUTPUT_REG_STAGES = 1
)
(
    input  logic clk1,
    input  logic reset,
    // High once every entry holds zero, stays high until reset
    output logic rdy,
    ram_port_if.mem port0,
    ram_port_if.mem port1
);

    logic [$clog2(N_ENTRIES)-1:0] init_addr;

    // Port 1 as seen by the RAM, muxed between the client and the clear loop
    ram_port_if #(.N_ENTRIES(N_ENTRIES), .N_DATA_BITS(N_DATA_BITS)) ram1_if ();

    ram_dualport
    #(
        .N_ENTRIES(N_ENTRIES),
        .N_DATA_BITS(N_DATA_BITS),
        .N_OUTPUT_REG_STAGES(N_OUTPUT_REG_STAGES)
    )
    u_ram
    (
        .clk1(clk1),
        .port0(port0),
        .port1(ram1_if.mem)
    );

    assign ram1_if.addr  = rdy ? port1.addr : init_addr;
    assign ram1_if.wen   = rdy ? port1.wen : 1'b1;
    assign ram1_if.wdata = rdy ? port1.wdata : '0;
    assign port1.rdata   = ram1_if.rdata;

    // One entry per cycle, rdy goes up on the edge that writes the last one
    always_ff @(posedge clk1)
    begin
        if (reset)
        begin
            rdy       <= 1'b0;
            init_addr <= '0;
        end
        else if (!rdy)
        begin
            init_addr <= init_addr + 1'b1;
            rdy       <= (init_addr == N_ENTRIES - 1);
        end
    end

endmodule

/* logic/ram_dualport.sv */
// ------------------------------------------------
// Single clock; same-address reads across ports are unspecified
// ------------------------------------------------
`timescale 1ns/1ps

module ram_dualport
#(
    parameter int N_ENTRIES = 32,
    parameter int N_DATA_BITS = 64,
    // Extra output register stages after the registered read
    parameter int N_OUTPUT_REG_STAGES = 1
)
(
    input  logic clk1,
    ram_port_if.mem port0,
    ram_port_if.mem port1
);

    logic [N_DATA_BITS-1:0] mem [N_ENTRIES];

    // Index 0 is the registered read, higher indices the extra stages
    logic [N_DATA_BITS-1:0] rd0 [N_OUTPUT_REG_STAGES+1];
    logic [N_DATA_BITS-1:0] rd1 [N_OUTPUT_REG_STAGES+1];

    // Both ports write the array, port 1 wins a same-address collision
    always_ff @(posedge clk1)
    begin
        if (port0.wen)
        begin
            mem[port0.addr] <= port0.wdata;
        end
        if (port1.wen)
        begin
            mem[port1.addr] <= port1.wdata;
        end
    end

    // A port that writes returns the new data on its own read path
    always_ff @(posedge clk1)
    begin
        rd0[0] <= port0.wen ? port0.wdata : mem[port0.addr];
        rd1[0] <= port1.wen ? port1.wdata : mem[port1.addr];
    end

    // Optional output pipeline, same depth on both ports
    for (genvar s = 0; s < N_OUTPUT_REG_STAGES; s++)
    begin : g_out_stage
        always_ff @(posedge clk1)
        begin
            rd0[s+1] <= rd0[s];
            rd1[s+1] <= rd1[s];
        end
    end

    assign port0.rdata = rd0[N_OUTPUT_REG_STAGES];
    assign port1.rdata = rd1[N_OUTPUT_REG_STAGES];

endmodule

/* logic/ram_port_if.sv */
// ------------------------------------------------
// One RAM port, address width derived from N_ENTRIES
// ------------------------------------------------
`timescale 1ns/1ps

interface ram_port_if
#(
    parameter int N_ENTRIES = 32,
    parameter int N_DATA_BITS = 64
);
    logic [$clog2(N_ENTRIES)-1:0] addr;
    logic                         wen;
    logic [N_DATA_BITS-1:0]       wdata;
    logic [N_DATA_BITS-1:0]       rdata;

    // The client side drives the request fields
    modport user (output addr, output wen, output wdata, input rdata);

    // The memory side returns read data
    modport mem (input addr, input wen, input wdata, output rdata);

endinterface

/* logic/ctr_pkg.sv */
// ------------------------------------------------
// Table sizes are fixed here, and the widths below must agree
// ------------------------------------------------

package ctr_pkg;

    // Number of counters in the table
    localparam int N_ENTRIES = 64;

    // Index width, enough to address every counter
    localparam int IDX_W = 6;

    // Each counter saturates at the top of this width
    localparam int COUNT_W = 16;

    // Width of the increment carried by one event
    localparam int INCR_W = 4;

    // Counter index
    typedef logic [IDX_W-1:0] idx_t;

    // Counter value as stored in the RAM
    typedef logic [COUNT_W-1:0] count_t;

    // Event increment, added to a counter per accepted event
    typedef logic [INCR_W-1:0] incr_t;

endpackage
